//--- common/adc_pkg.sv
package adc_pkg;

  // ******************************
  // sample widths and words
  // ******************************

  // fixed by the converter, not tunable
  localparam int adc_width = 14;

  typedef logic [adc_width-1:0] adc_word_t;

  // one adc_clk worth of ddr input, already sampled on both edges
  typedef struct packed {
    adc_word_t rise;
    adc_word_t fall;
    logic      or_rise;
    logic      or_fall;
  } ddr_word_t;

  // paired channels, 30 bits
  typedef struct packed {
    adc_word_t data_a;
    adc_word_t data_b;
    logic      or_a;
    logic      or_b;
  } chan_pair_t;

  // cfg register layout, bit 2 down to bit 0
  typedef struct packed {
    logic edgesel;
    logic pin_mode;
    logic twos_comp;
  } adc_cfg_t;

  // ******************************
  // register port
  // ******************************

  typedef logic [1:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  typedef struct packed {
    logic      wr;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  localparam reg_addr_t addr_cfg        = 2'd0;
  localparam reg_addr_t addr_or_status  = 2'd1;
  localparam reg_addr_t addr_or_count_a = 2'd2;
  localparam reg_addr_t addr_or_count_b = 2'd3;

  // four-phase handshake states
  typedef enum logic [1:0] {
    idle,
    access,
    wait_release
  } ctrl_state_t;

endpackage

//--- adc_if/adc_ddr_deinterleave.sv
`timescale 1ns/10ps

module adc_ddr_deinterleave (
  input  logic                adc_clk,
  input  logic                arst_n,
  input  adc_pkg::ddr_word_t  ddr_in,
  input  logic                edgesel,
  input  logic                pin_mode,
  output adc_pkg::chan_pair_t pair_raw,
  output logic                pair_valid
);

  // one channel's half of the pins in interleaved mode
  localparam int half = adc_pkg::adc_width / 2;

  // stage 1 capture and the rise word of the previous row
  adc_pkg::ddr_word_t  cap_q;
  adc_pkg::adc_word_t  rise_d;
  logic                or_rise_d;

  // stage 2 edge pairing
  adc_pkg::chan_pair_t mux_q;

  // bit de-interleave of the paired words
  adc_pkg::chan_pair_t deint;

  // pipeline fill with one bit per register stage
  logic [2:0]          fill_q;

  // ******************************
  // stage 1 capture
  // ******************************

  always_ff @(posedge adc_clk) begin
    cap_q     <= ddr_in;
    // delayed rise word for a pair that spans two rows
    rise_d    <= cap_q.rise;
    or_rise_d <= cap_q.or_rise;
  end

  // ******************************
  // stage 2 pairing across edges
  // ******************************

  always_ff @(posedge adc_clk) begin
    if (edgesel) begin
      // a from the rise of the previous row and b from the fall of this row
      mux_q.data_a <= rise_d;
      mux_q.data_b <= cap_q.fall;
      mux_q.or_a   <= or_rise_d;
      mux_q.or_b   <= cap_q.or_fall;
    end else begin
      // both words from the same row with the fall edge as channel a
      mux_q.data_a <= cap_q.fall;
      mux_q.data_b <= cap_q.rise;
      mux_q.or_a   <= cap_q.or_fall;
      mux_q.or_b   <= cap_q.or_rise;
    end
  end

  // ******************************
  // stage 3 pin mode
  // ******************************

  // interleaved pins carry b above a bit by bit
  // upper halves build channel a and lower halves build channel b
  always_comb begin
    deint = mux_q;
    for (int i = 0; i < half; i++) begin
      deint.data_a[2*i+1] = mux_q.data_b[half+i];
      deint.data_a[2*i]   = mux_q.data_a[half+i];
      deint.data_b[2*i+1] = mux_q.data_b[i];
      deint.data_b[2*i]   = mux_q.data_a[i];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (pin_mode) begin
      pair_raw <= mux_q;
    end else begin
      pair_raw <= deint;
    end
  end

  // valid once all three stages hold real data
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_q <= '0;
    end else begin
      fill_q <= {fill_q[1:0], 1'b1};
    end
  end

  assign pair_valid = fill_q[2];

endmodule

//--- verilog/adc_sample_format.sv
`timescale 1ns/10ps

module adc_sample_format (
  input  logic               adc_clk,
  input  logic               arst_n,
  input  logic               twos_comp,
  input  adc_pkg::adc_word_t data_in,
  input  logic               or_in,
  input  logic               valid_in,
  output adc_pkg::adc_word_t data_out,
  output logic               or_out,
  output logic               valid_out
);

  // msb position of a sample
  localparam int msb = adc_pkg::adc_width - 1;

  adc_pkg::adc_word_t data_fmt;

  // ******************************
  // format
  // ******************************

  // offset binary to two's complement is a flip of the msb
  always_comb begin
    data_fmt = data_in;
    if (twos_comp) begin
      data_fmt[msb] = ~data_in[msb];
    end
  end

  // sample and over-range travel together
  always_ff @(posedge adc_clk) begin
    data_out <= data_fmt;
    or_out   <= or_in;
  end

  // valid follows the data by one stage
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

endmodule

//--- verilog/adc_overrange_monitor.sv
`timescale 1ns/10ps

module adc_overrange_monitor #(
  parameter int cnt_width = 16
) (
  input  logic                 adc_clk,
  input  logic                 arst_n,
  input  logic                 or_a,
  input  logic                 or_b,
  input  logic                 valid,
  input  logic                 clear_a,
  input  logic                 clear_b,
  output logic [1:0]           sticky,
  output logic [cnt_width-1:0] count_a,
  output logic [cnt_width-1:0] count_b
);

  // index 0 is channel a, index 1 is channel b
  logic [1:0]           hit;
  logic [1:0]           clear;
  logic [cnt_width-1:0] count_q [2];

  // only valid samples count
  assign hit   = {or_b, or_a} & {2{valid}};
  assign clear = {clear_b, clear_a};

  // ******************************
  // per channel flag and counter
  // ******************************

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    always_ff @(posedge adc_clk or negedge arst_n) begin
      if (!arst_n) begin
        sticky[ch]  <= 1'b0;
        count_q[ch] <= '0;
      end else if (clear[ch]) begin
        // clear wins over a hit in the same cycle
        sticky[ch]  <= 1'b0;
        count_q[ch] <= '0;
      end else if (hit[ch]) begin
        sticky[ch] <= 1'b1;
        // hold at full scale instead of wrapping
        if (count_q[ch] != '1) begin
          count_q[ch] <= count_q[ch] + 1'b1;
        end
      end
    end
  end

  assign count_a = count_q[0];
  assign count_b = count_q[1];

endmodule

//--- verilog/adc_ctrl.sv
`timescale 1ns/10ps

module adc_ctrl #(
  parameter int cnt_width = 16
) (
  input  logic                 adc_clk,
  input  logic                 arst_n,
  input  logic                 req,
  input  adc_pkg::reg_req_t    req_data,
  output logic                 ack,
  output adc_pkg::reg_data_t   rdata,
  output adc_pkg::adc_cfg_t    cfg,
  input  logic [1:0]           sticky,
  input  logic [cnt_width-1:0] count_a,
  input  logic [cnt_width-1:0] count_b,
  output logic                 clear_a,
  output logic                 clear_b
);

  adc_pkg::ctrl_state_t state;
  adc_pkg::reg_req_t    req_q;
  adc_pkg::reg_data_t   rd_mux;

  // ******************************
  // request capture
  // ******************************

  // held stable by the host for the whole handshake
  always_ff @(posedge adc_clk) begin
    if (state == adc_pkg::idle && req) begin
      req_q <= req_data;
    end
  end

  // ******************************
  // read mux
  // ******************************

  // counters read zero extended
  always_comb begin
    case (req_q.addr)
      adc_pkg::addr_cfg: begin
        rd_mux = adc_pkg::reg_data_t'(cfg);
      end
      adc_pkg::addr_or_status: begin
        rd_mux = adc_pkg::reg_data_t'(sticky);
      end
      adc_pkg::addr_or_count_a: begin
        rd_mux = adc_pkg::reg_data_t'(count_a);
      end
      default: begin
        rd_mux = adc_pkg::reg_data_t'(count_b);
      end
    endcase
  end

  // ******************************
  // four-phase fsm
  // ******************************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= adc_pkg::idle;
      ack     <= 1'b0;
      rdata   <= '0;
      cfg     <= '0;
      clear_a <= 1'b0;
      clear_b <= 1'b0;
    end else begin
      // clears are single cycle pulses
      clear_a <= 1'b0;
      clear_b <= 1'b0;
      case (state)
        adc_pkg::idle: begin
          if (req) begin
            state <= adc_pkg::access;
          end
        end
        adc_pkg::access: begin
          // the access itself, ack goes up on this edge
          ack   <= 1'b1;
          state <= adc_pkg::wait_release;
          if (req_q.wr) begin
            rdata <= '0;
            if (req_q.addr == adc_pkg::addr_cfg) begin
              cfg <= adc_pkg::adc_cfg_t'(req_q.wdata[$bits(adc_pkg::adc_cfg_t)-1:0]);
            end
            // write one to clear flag and count of a channel
            if (req_q.addr == adc_pkg::addr_or_status) begin
              clear_a <= req_q.wdata[0];
              clear_b <= req_q.wdata[1];
            end
          end else begin
            rdata <= rd_mux;
          end
        end
        adc_pkg::wait_release: begin
          // host drops req, then ack follows
          if (!req) begin
            ack   <= 1'b0;
            state <= adc_pkg::idle;
          end
        end
        default: begin
          state <= adc_pkg::idle;
        end
      endcase
    end
  end

endmodule

//--- verilog/adc_capture_top.sv
`timescale 1ns/10ps

module adc_capture_top #(
  parameter int cnt_width = 16
) (
  input  logic                adc_clk,
  input  logic                arst_n,
  input  adc_pkg::ddr_word_t  ddr_in,
  input  logic                req,
  input  adc_pkg::reg_req_t   req_data,
  output logic                ack,
  output adc_pkg::reg_data_t  rdata,
  output adc_pkg::chan_pair_t samples,
  output logic                sample_valid
);

  adc_pkg::adc_cfg_t    cfg;
  adc_pkg::chan_pair_t  pair_raw;
  logic                 pair_valid;
  logic                 clear_a;
  logic                 clear_b;
  logic [1:0]           sticky;
  logic [cnt_width-1:0] count_a;
  logic [cnt_width-1:0] count_b;

  // ******************************
  // register port and config
  // ******************************

  adc_ctrl #(
    .cnt_width (cnt_width)
  ) i_ctrl (
    .adc_clk  (adc_clk),
    .arst_n   (arst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rdata    (rdata),
    .cfg      (cfg),
    .sticky   (sticky),
    .count_a  (count_a),
    .count_b  (count_b),
    .clear_a  (clear_a),
    .clear_b  (clear_b)
  );

  // ******************************
  // datapath
  // ******************************

  adc_ddr_deinterleave i_deinterleave (
    .adc_clk    (adc_clk),
    .arst_n     (arst_n),
    .ddr_in     (ddr_in),
    .edgesel    (cfg.edgesel),
    .pin_mode   (cfg.pin_mode),
    .pair_raw   (pair_raw),
    .pair_valid (pair_valid)
  );

  // channel a also owns the output valid
  adc_sample_format i_format_a (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .twos_comp (cfg.twos_comp),
    .data_in   (pair_raw.data_a),
    .or_in     (pair_raw.or_a),
    .valid_in  (pair_valid),
    .data_out  (samples.data_a),
    .or_out    (samples.or_a),
    .valid_out (sample_valid)
  );

  // same timing as channel a, its valid is redundant
  adc_sample_format i_format_b (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .twos_comp (cfg.twos_comp),
    .data_in   (pair_raw.data_b),
    .or_in     (pair_raw.or_b),
    .valid_in  (pair_valid),
    .data_out  (samples.data_b),
    .or_out    (samples.or_b),
    .valid_out ()
  );

  // watches the formatted over-range bits
  adc_overrange_monitor #(
    .cnt_width (cnt_width)
  ) i_or_monitor (
    .adc_clk (adc_clk),
    .arst_n  (arst_n),
    .or_a    (samples.or_a),
    .or_b    (samples.or_b),
    .valid   (sample_valid),
    .clear_a (clear_a),
    .clear_b (clear_b),
    .sticky  (sticky),
    .count_a (count_a),
    .count_b (count_b)
  );

endmodule

//--- testbench/tb_adc_capture.sv
`timescale 1ns/10ps

module tb_adc_capture;

  // ******************************
  // constants
  // ******************************

  // ddr row to samples output in adc_clk cycles
  localparam int pipe_depth      = 4;
  // idle cycles before a register access so the monitor has seen every row
  localparam int drain_cycles    = pipe_depth + 1;
  // outputs after a cfg write that may mix old and new settings
  localparam int cfg_skip        = 4;
  // timeout budget of twice 8 cycles per stimulus line
  localparam int cycles_per_line = 16;

  logic                adc_clk;
  logic                arst_n;
  adc_pkg::ddr_word_t  ddr_in;
  logic                req;
  adc_pkg::reg_req_t   req_data;
  logic                ack;
  adc_pkg::reg_data_t  rdata;
  adc_pkg::chan_pair_t samples;
  logic                sample_valid;

  // expected outputs in flight with one entry per driven cycle
  adc_pkg::chan_pair_t exp_q [$];
  logic                chk_q [$];
  adc_pkg::ddr_word_t  last_row;
  int                  out_count;
  int                  cycle_count;
  int                  cycle_limit;

  adc_capture_top #(
    .cnt_width (16)
  ) i_dut (
    .adc_clk      (adc_clk),
    .arst_n       (arst_n),
    .ddr_in       (ddr_in),
    .req          (req),
    .req_data     (req_data),
    .ack          (ack),
    .rdata        (rdata),
    .samples      (samples),
    .sample_valid (sample_valid)
  );

  // ******************************
  // helpers
  // ******************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped at first failure");
  endtask

  // one falling edge checks what came out and then drives the next row
  task automatic step_cycle(input adc_pkg::ddr_word_t row, input logic chk,
                            input adc_pkg::chan_pair_t exp);
    adc_pkg::chan_pair_t want;
    logic                want_chk;
    @(negedge adc_clk);
    // outputs now belong to the row driven pipe_depth cycles ago
    if (exp_q.size() == pipe_depth) begin
      want     = exp_q.pop_front();
      want_chk = chk_q.pop_front();
      if (want_chk) begin
        assert (samples === want) else begin
          abort_run($sformatf("** Error @ %0t: a=%h b=%h or=%b%b, want a=%h b=%h or=%b%b",
                              $time, samples.data_a, samples.data_b, samples.or_a,
                              samples.or_b, want.data_a, want.data_b, want.or_a, want.or_b));
        end
      end
    end
    // the release edge already showed one low output
    if (out_count < pipe_depth - 1) begin
      assert (sample_valid === 1'b0) else begin
        abort_run($sformatf("** Error @ %0t: sample_valid high during pipeline fill", $time));
      end
      out_count++;
    end else begin
      assert (sample_valid === 1'b1) else begin
        abort_run($sformatf("** Error @ %0t: sample_valid low after pipeline fill", $time));
      end
    end
    ddr_in   = row;
    last_row = row;
    exp_q.push_back(exp);
    chk_q.push_back(chk);
  endtask

  // hold the data words with over-range off so the counts stay put
  task automatic idle_cycle();
    adc_pkg::ddr_word_t row;
    row         = last_row;
    row.or_rise = 1'b0;
    row.or_fall = 1'b0;
    step_cycle(row, 1'b0, '0);
  endtask

  // full four-phase transaction that waits on ack after each req edge
  task automatic reg_access(input logic wr, input adc_pkg::reg_addr_t addr,
                            input adc_pkg::reg_data_t wdata,
                            input adc_pkg::reg_data_t rd_exp);
    repeat (drain_cycles) begin
      idle_cycle();
    end
    assert (ack === 1'b0) else begin
      abort_run("ack was still high when a new request was due");
    end
    req_data.wr    = wr;
    req_data.addr  = addr;
    req_data.wdata = wdata;
    req            = 1'b1;
    // ack comes up once the access is done
    while (ack !== 1'b1) begin
      idle_cycle();
    end
    if (!wr) begin
      assert (rdata === rd_exp) else begin
        abort_run($sformatf("** Error @ %0t: register %0d read %h, expected %h",
                            $time, addr, rdata, rd_exp));
      end
    end
    req = 1'b0;
    while (ack !== 1'b0) begin
      idle_cycle();
    end
  endtask

  // ******************************
  // clock and watchdog
  // ******************************

  initial begin
    adc_clk = 1'b0;
    forever begin
      #10 adc_clk = ~adc_clk;
    end
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge adc_clk);
      cycle_count++;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
        abort_run($sformatf("timeout, run not finished after %0d cycles", cycle_limit));
      end
    end
  end

  // ******************************
  // stimulus from file
  // ******************************

  initial begin
    int                  fd;
    int                  n;
    int                  skip_rows;
    string               line;
    string               lines [$];
    logic [7:0]          tag;
    logic                wr;
    adc_pkg::reg_addr_t  addr;
    adc_pkg::reg_data_t  wdata;
    adc_pkg::reg_data_t  rd_exp;
    adc_pkg::adc_word_t  rise;
    adc_pkg::adc_word_t  fall;
    adc_pkg::adc_word_t  exp_a;
    adc_pkg::adc_word_t  exp_b;
    logic                or_rise;
    logic                or_fall;
    logic                exp_or_a;
    logic                exp_or_b;
    adc_pkg::ddr_word_t  row;
    adc_pkg::chan_pair_t exp;
    cycle_limit = 0;
    out_count   = 0;
    skip_rows   = 0;
    arst_n      = 1'b0;
    req         = 1'b0;
    req_data    = '0;
    ddr_in      = '0;
    last_row    = '0;

    fd = $fopen("testbench/adc_capture_input.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open testbench/adc_capture_input.txt");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0) begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    cycle_limit = lines.size() * cycles_per_line;

    // reset held over three rising edges
    repeat (3) begin
      @(negedge adc_clk);
      assert (ack === 1'b0 && sample_valid === 1'b0) else begin
        abort_run($sformatf("** Error @ %0t: ack or sample_valid high in reset", $time));
      end
    end
    arst_n = 1'b1;

    foreach (lines[i]) begin
      line = lines[i];
      tag  = line.getc(0);
      if (line.len() < 4 || tag == "#") begin
        // comment or blank line
      end else if (tag == "c") begin
        n = $sscanf(line.substr(3, line.len() - 1), "%h", wdata);
        if (n != 1) begin
          abort_run({"malformed cfg line: ", line});
        end
        reg_access(1'b1, adc_pkg::addr_cfg, wdata, '0);
        skip_rows = cfg_skip;
      end else if (tag == "r") begin
        n = $sscanf(line.substr(3, line.len() - 1), "%h %h %h %h", wr, addr, wdata, rd_exp);
        if (n != 4) begin
          abort_run({"malformed reg line: ", line});
        end
        reg_access(wr, addr, wdata, rd_exp);
      end else if (tag == "d") begin
        n = $sscanf(line.substr(4, line.len() - 1), "%h %h %h %h %h %h %h %h",
                    rise, fall, or_rise, or_fall, exp_a, exp_b, exp_or_a, exp_or_b);
        if (n != 8) begin
          abort_run({"malformed data line: ", line});
        end
        row = {rise, fall, or_rise, or_fall};
        exp = {exp_a, exp_b, exp_or_a, exp_or_b};
        // rows right after a cfg write are driven but not compared
        step_cycle(row, skip_rows == 0, exp);
        if (skip_rows > 0) begin
          skip_rows--;
        end
      end else begin
        abort_run({"unknown stimulus line: ", line});
      end
    end

    // flush the pipeline so the last rows get checked
    repeat (pipe_depth) begin
      idle_cycle();
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- testbench/adc_capture_input.txt
# cfg <value> | reg <wr> <addr> <wdata> <rdata, unused on writes>
# data <rise> <fall> <or_rise> <or_fall> <data_a> <data_b> <or_a> <or_b>, all hex
# edgesel 0, full word pins
cfg 0002
data 0100 0200 0 0 0200 0100 0 0
data 0111 0222 0 0 0222 0111 0 0
data 0123 3210 0 0 3210 0123 0 0
data 1fff 2000 0 0 2000 1fff 0 0
data 0abc 1def 0 1 1def 0abc 1 0
data 3fff 0000 1 1 0000 3fff 1 1
data 1234 2345 1 1 2345 1234 1 1
reg 0 1 0000 0003
reg 0 2 0000 0003
reg 0 3 0000 0002
reg 1 1 0001 0000
reg 0 1 0000 0002
reg 0 2 0000 0000
reg 0 3 0000 0002
# edgesel 1, channel a from the previous row
cfg 0006
data 0001 0002 0 0 1234 0002 0 0
data 0003 0004 0 0 0001 0004 0 0
data 0005 0006 0 0 0003 0006 0 0
data 0007 0008 0 0 0005 0008 0 0
data 1111 2222 0 1 0007 2222 0 1
data 3333 0444 1 0 1111 0444 0 0
data 0555 3666 0 0 3333 3666 1 0
reg 0 0 0000 0006
# interleaved pins with two's complement
cfg 0001
data 0000 0000 0 0 2000 2000 0 0
data 0000 0000 0 0 2000 2000 0 0
data 0000 0000 0 0 2000 2000 0 0
data 0000 0000 0 0 2000 2000 0 0
data 3fff 0000 0 0 0aaa 0aaa 0 0
data 3f80 007f 1 0 0aaa 3555 0 1
data 2000 0001 0 0 0000 2001 0 0

//--- build.f
common/adc_pkg.sv
adc_if/adc_ddr_deinterleave.sv
verilog/adc_sample_format.sv
verilog/adc_overrange_monitor.sv
verilog/adc_ctrl.sv
verilog/adc_capture_top.sv
testbench/tb_adc_capture.sv

//--- Makefile
# Verilator build and run of the ADC capture testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_capture
OBJ_DIR   ?= obj_dir
FLIST     ?= build.f
VFLAGS    ?= --binary --assert -j 0

# sources taken from the file list, option lines skipped
SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status is non-zero when the testbench stops with $fatal
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
